// ==== btac.f ====
logic/btac_pkg.sv
logic/btb.sv
logic/bht.sv
logic/btac_lookup.sv
logic/btac_resolve.sv
logic/btac_update.sv
logic/btac.sv
bench/btac_tb.sv

// ==== bench/btac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_tb
  import btac_pkg::*;
();

  typedef struct packed {
    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] npc;
    logic [addr_width-1:0] addr;
    logic [addr_width-1:0] taddr;
    logic                  jump;
    logic                  taken;
    logic [1:0]            tsat;
  } upd_t;

  typedef struct packed {
    logic [3:0]            test;
    logic                  stall;
    logic                  clear;
    logic [addr_width-1:0] get0;
    logic [addr_width-1:0] get1;
    upd_t                  lane0;
    upd_t                  lane1;
  } row_t;

  localparam upd_t idle = '0;
  localparam logic [addr_width-1:0] pc_a = 32'h0000_1010; // BTB index 8, BHT index 8.
  localparam logic [addr_width-1:0] pc_b = 32'h0000_4020;

  logic clock;
  logic reset;
  logic clear;
  logic stall;
  logic [addr_width-1:0] get_pc0, get_pc1;
  logic [addr_width-1:0] upd_pc0, upd_pc1, upd_npc0, upd_npc1, upd_addr0, upd_addr1;
  logic upd_jump0, upd_jump1, upd_taken0, upd_taken1;
  logic [addr_width-1:0] upd_taddr0, upd_taddr1;
  logic [1:0] upd_tsat0, upd_tsat1;
  logic pred_taken0, pred_taken1, pred_miss, pred_hazard;
  logic [addr_width-1:0] pred_taddr0, pred_taddr1, pred_maddr;
  logic [1:0] pred_tsat0, pred_tsat1;

  row_t  rows [0:39];
  string test_names [0:5];
  int    n_rows = 0;
  int    errors = 0;
  int    test_errors = 0;
  int    checks = 0;
  int    failed_tests = 0;
  int unsigned seed_value;

  // Reference tables and the lookup still in flight.
  logic [btb_entry_width-1:0] btb_model [0:btb_entries-1];
  logic [1:0]                 bht_model [0:bht_entries-1];
  logic [btb_entry_width-1:0] pend_entry0, pend_entry1;
  logic [1:0]                 pend_cnt0, pend_cnt1;
  logic [addr_width-1:0]      held0, held1, pend_maddr;
  logic                       pend_miss;

  btac btac_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic upd_t branch(input logic [addr_width-1:0] pc, addr,
                                  input logic jump, taken,
                                  input logic [addr_width-1:0] taddr,
                                  input logic [1:0] tsat);
    upd_t u;
    u.pc = pc;
    u.npc = pc + 4;
    u.addr = addr;
    u.taddr = taddr;
    u.jump = jump;
    u.taken = taken;
    u.tsat = tsat;
    return u;
  endfunction

  function automatic logic lane_miss(input logic flush, input upd_t u);
    return !flush && (u.jump || u.taken) && !(u.jump && u.taken && u.addr == u.taddr);
  endfunction

  function automatic logic [1:0] next_count(input logic [1:0] cnt, input logic jump);
    if (jump) begin
      return (cnt == 2'd3) ? cnt : cnt + 2'd1;
    end
    return (cnt == 2'd0) ? cnt : cnt - 2'd1;
  endfunction

  task automatic compare(input string name, input logic [addr_width-1:0] got,
                         input logic [addr_width-1:0] expected);
    checks++;
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic add_row(input int test, input logic stall_in, clear_in,
                         input logic [addr_width-1:0] g0, g1, input upd_t l0, l1);
    rows[n_rows].test = test[3:0];
    rows[n_rows].stall = stall_in;
    rows[n_rows].clear = clear_in;
    rows[n_rows].get0 = g0;
    rows[n_rows].get1 = g1;
    rows[n_rows].lane0 = l0;
    rows[n_rows].lane1 = l1;
    n_rows++;
  endtask

  task automatic build_table();
    logic [addr_width-1:0] alias_pc;
    alias_pc = ($urandom() & 32'hffff_fe00) | (pc_a & 32'h1ff); // Same BTB and BHT index.
    if (alias_pc[31:7] == pc_a[31:7]) begin
      alias_pc[31] = ~alias_pc[31];
    end
    test_names = '{"reset", "training", "misses", "tag alias", "stall and clear", "dual update"};
    add_row(0, 0, 0, pc_a, 32'h0000_0100, idle, idle);
    add_row(0, 0, 0, 32'h8000_0044, 32'h0000_0ffe, idle, idle);
    add_row(0, 0, 0, 0, 0, idle, idle);
    add_row(1, 0, 0, pc_a, 0, branch(pc_a, 32'h2000, 1, 0, 0, 2'd0), idle);
    add_row(1, 0, 0, pc_a, 0, branch(pc_a, 32'h2000, 1, 0, 0, 2'd1), idle);
    add_row(1, 0, 0, pc_a, 0, idle, idle);
    add_row(1, 0, 0, pc_a, 0, branch(pc_a, 32'h2000, 1, 1, 32'h2000, 2'd2), idle);
    add_row(1, 0, 0, pc_a, 0, idle, idle);
    add_row(1, 0, 0, 0, 0, idle, idle);
    add_row(2, 0, 0, pc_a, 0, branch(pc_a, 32'h3000, 1, 1, 32'h2000, 2'd3), idle);
    add_row(2, 0, 0, pc_a, 0, idle, idle);
    add_row(2, 0, 0, pc_a, 0, branch(pc_a, 32'h3000, 0, 1, 32'h3000, 2'd3), idle);
    add_row(2, 0, 0, pc_a, 0, idle, idle);
    add_row(2, 0, 0, 0, 0, idle, idle);
    add_row(3, 0, 0, alias_pc, pc_a, idle, idle);
    add_row(3, 0, 0, 0, 0, idle, idle);
    add_row(4, 0, 0, pc_a, 0, idle, idle);
    add_row(4, 1, 0, pc_a, 0, idle, idle); // Outputs zeroed.
    add_row(4, 0, 0, pc_a, 0, idle, idle);
    add_row(4, 0, 1, 32'h0000_0a00, 0, branch(pc_a, 32'h3000, 0, 1, 32'h3000, 2'd2), idle);
    add_row(4, 0, 0, pc_a, 0, idle, idle);
    add_row(4, 0, 0, 0, 0, idle, idle);
    add_row(5, 0, 0, pc_a, pc_b, branch(pc_a, 32'h5000, 1, 1, 32'h3000, 2'd2),
            branch(pc_b, 32'h6000, 1, 0, 0, 2'd0));
    add_row(5, 0, 0, pc_a, pc_b, idle, idle);
    add_row(5, 0, 0, 0, 0, idle, idle);
    add_row(5, 0, 0, 0, pc_b, idle, branch(pc_b, 32'h6000, 1, 0, 0, 2'd0)); // Lane 1 alone.
    add_row(5, 0, 0, 0, pc_b, idle, idle);
    add_row(5, 0, 0, 0, 0, idle, idle);
  endtask

  task automatic drive(input row_t r);
    stall = r.stall;
    clear = r.clear;
    get_pc0 = r.get0;
    get_pc1 = r.get1;
    {upd_pc0, upd_npc0, upd_addr0, upd_taddr0} =
        {r.lane0.pc, r.lane0.npc, r.lane0.addr, r.lane0.taddr};
    {upd_pc1, upd_npc1, upd_addr1, upd_taddr1} =
        {r.lane1.pc, r.lane1.npc, r.lane1.addr, r.lane1.taddr};
    {upd_jump0, upd_taken0, upd_tsat0} = {r.lane0.jump, r.lane0.taken, r.lane0.tsat};
    {upd_jump1, upd_taken1, upd_tsat1} = {r.lane1.jump, r.lane1.taken, r.lane1.tsat};
  endtask

  task automatic check_prediction(input string lane, input logic ok,
                                  input logic [btb_entry_width-1:0] entry,
                                  input logic [1:0] cnt, input logic [addr_width-1:0] pc,
                                  input logic taken, input logic [addr_width-1:0] taddr,
                                  input logic [1:0] tsat);
    logic hit;
    hit = entry[btb_entry_width-1:addr_width] == pc[addr_width-1:btb_index_width+1];
    compare({"pred_taken", lane}, taken, ok && cnt[1] && hit);
    compare({"pred_taddr", lane}, taddr, ok ? entry[addr_width-1:0] : '0);
    compare({"pred_tsat", lane}, tsat, ok ? cnt : 2'd0);
  endtask

  task automatic advance_model(input row_t r);
    logic [addr_width-1:0] sel0, sel1;
    logic miss0, miss1, event0, event1;
    upd_t w;
    sel0 = r.clear ? held0 : r.get0; // Clear repeats the held lookup.
    sel1 = r.clear ? held1 : r.get1;
    pend_entry0 = btb_model[sel0[btb_index_width:1]];
    pend_entry1 = btb_model[sel1[btb_index_width:1]];
    pend_cnt0 = bht_model[sel0[bht_index_width:1]];
    pend_cnt1 = bht_model[sel1[bht_index_width:1]];
    held0 = sel0;
    held1 = sel1;
    miss0 = lane_miss(r.clear, r.lane0);
    miss1 = lane_miss(r.clear, r.lane1);
    pend_miss = miss0 || miss1;
    w = miss0 ? r.lane0 : r.lane1;
    pend_maddr = w.jump ? w.addr : w.npc;
    event0 = !r.clear && (r.lane0.jump || r.lane0.taken);
    event1 = !r.clear && (r.lane1.jump || r.lane1.taken);
    if (event0 || event1) begin
      w = event0 ? r.lane0 : r.lane1;
      btb_model[w.pc[btb_index_width:1]] = {w.pc[addr_width-1:btb_index_width+1], w.addr};
      bht_model[w.pc[bht_index_width:1]] = next_count(w.tsat, w.jump);
    end
  endtask

  initial begin
    reset = 1'b0;
    drive('0);
    seed_value = $urandom(42);
    for (int i = 0; i < btb_entries; i++) btb_model[i] = '0;
    for (int i = 0; i < bht_entries; i++) bht_model[i] = '0;
    {pend_entry0, pend_entry1, pend_cnt0, pend_cnt1} = '0;
    {held0, held1, pend_miss, pend_maddr} = '0;
    build_table();
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(negedge clock);
      drive(rows[i]);
      #5; // Middle of the low phase.
      check_prediction("0", !rows[i].stall && !rows[i].clear, pend_entry0, pend_cnt0, held0,
                       pred_taken0, pred_taddr0, pred_tsat0);
      check_prediction("1", !rows[i].stall && !rows[i].clear, pend_entry1, pend_cnt1, held1,
                       pred_taken1, pred_taddr1, pred_tsat1);
      compare("pred_hazard", pred_hazard, lane_miss(rows[i].clear, rows[i].lane0));
      compare("pred_miss", pred_miss, pend_miss);
      if (pend_miss) begin
        compare("pred_maddr", pred_maddr, pend_maddr);
      end
      advance_model(rows[i]);
      if (i == n_rows - 1 || rows[i + 1].test != rows[i].test) begin
        $display("Test %0d (%s): %s, %0d mismatches", rows[i].test,
                 test_names[rows[i].test], (test_errors == 0) ? "ok" : "failed", test_errors);
        if (test_errors != 0) failed_tests++;
        test_errors = 0;
      end
    end
    $display("Summary: %0d rows, %0d checks, %0d mismatches, %0d tests failed",
             n_rows, checks, errors, failed_tests);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (n_rows * 4 + 5) @(posedge clock);
    $display("Timeout: the row loop did not finish within %0d cycles", n_rows * 4 + 5);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/btac.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac
  import btac_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  stall,
  input  logic [addr_width-1:0] get_pc0,
  input  logic [addr_width-1:0] get_pc1,
  input  logic [addr_width-1:0] upd_pc0,
  input  logic [addr_width-1:0] upd_pc1,
  input  logic [addr_width-1:0] upd_npc0,
  input  logic [addr_width-1:0] upd_npc1,
  input  logic [addr_width-1:0] upd_addr0,
  input  logic [addr_width-1:0] upd_addr1,
  input  logic                  upd_jump0,
  input  logic                  upd_jump1,
  input  logic                  upd_taken0,
  input  logic                  upd_taken1,
  input  logic [addr_width-1:0] upd_taddr0,
  input  logic [addr_width-1:0] upd_taddr1,
  input  logic [1:0]            upd_tsat0,
  input  logic [1:0]            upd_tsat1,
  output logic                  pred_taken0,
  output logic                  pred_taken1,
  output logic [addr_width-1:0] pred_taddr0,
  output logic [addr_width-1:0] pred_taddr1,
  output logic [1:0]            pred_tsat0,
  output logic [1:0]            pred_tsat1,
  output logic                  pred_miss,
  output logic [addr_width-1:0] pred_maddr,
  output logic                  pred_hazard
);

  logic [btb_index_width-1:0] btb_raddr0;
  logic [btb_index_width-1:0] btb_raddr1;
  logic [btb_entry_width-1:0] btb_rdata0;
  logic [btb_entry_width-1:0] btb_rdata1;
  logic                       btb_wen;
  logic [btb_index_width-1:0] btb_waddr;
  logic [btb_entry_width-1:0] btb_wdata;
  logic [bht_index_width-1:0] bht_raddr0;
  logic [bht_index_width-1:0] bht_raddr1;
  logic [1:0]                 bht_rdata0;
  logic [1:0]                 bht_rdata1;
  logic                       bht_wen;
  logic [bht_index_width-1:0] bht_waddr;
  logic [1:0]                 bht_wdata;
  resolve_kind_t              kind0;
  resolve_kind_t              kind1;

  btac_lookup lookup_i (
    .clock      (clock),
    .reset      (reset),
    .clear      (clear),
    .stall      (stall),
    .get_pc0    (get_pc0),
    .get_pc1    (get_pc1),
    .btb_rdata0 (btb_rdata0),
    .btb_rdata1 (btb_rdata1),
    .bht_rdata0 (bht_rdata0),
    .bht_rdata1 (bht_rdata1),
    .btb_raddr0 (btb_raddr0),
    .btb_raddr1 (btb_raddr1),
    .bht_raddr0 (bht_raddr0),
    .bht_raddr1 (bht_raddr1),
    .pred_taken0(pred_taken0),
    .pred_taken1(pred_taken1),
    .pred_taddr0(pred_taddr0),
    .pred_taddr1(pred_taddr1),
    .pred_tsat0 (pred_tsat0),
    .pred_tsat1 (pred_tsat1)
  );

  btac_resolve resolve_i (
    .clock      (clock),
    .reset      (reset),
    .clear      (clear),
    .upd_jump0  (upd_jump0),
    .upd_jump1  (upd_jump1),
    .upd_taken0 (upd_taken0),
    .upd_taken1 (upd_taken1),
    .upd_addr0  (upd_addr0),
    .upd_addr1  (upd_addr1),
    .upd_taddr0 (upd_taddr0),
    .upd_taddr1 (upd_taddr1),
    .upd_npc0   (upd_npc0),
    .upd_npc1   (upd_npc1),
    .kind0      (kind0),
    .kind1      (kind1),
    .pred_miss  (pred_miss),
    .pred_maddr (pred_maddr),
    .pred_hazard(pred_hazard)
  );

  btac_update update_i (
    .upd_pc0  (upd_pc0),
    .upd_pc1  (upd_pc1),
    .upd_addr0(upd_addr0),
    .upd_addr1(upd_addr1),
    .upd_tsat0(upd_tsat0),
    .upd_tsat1(upd_tsat1),
    .upd_jump0(upd_jump0),
    .upd_jump1(upd_jump1),
    .kind0    (kind0),
    .kind1    (kind1),
    .btb_wen  (btb_wen),
    .btb_waddr(btb_waddr),
    .btb_wdata(btb_wdata),
    .bht_wen  (bht_wen),
    .bht_waddr(bht_waddr),
    .bht_wdata(bht_wdata)
  );

  btb btb_i (
    .clock (clock),
    .wen   (btb_wen),
    .waddr (btb_waddr),
    .wdata (btb_wdata),
    .raddr0(btb_raddr0),
    .raddr1(btb_raddr1),
    .rdata0(btb_rdata0),
    .rdata1(btb_rdata1)
  );

  bht bht_i (
    .clock (clock),
    .wen   (bht_wen),
    .waddr (bht_waddr),
    .wdata (bht_wdata),
    .raddr0(bht_raddr0),
    .raddr1(bht_raddr1),
    .rdata0(bht_rdata0),
    .rdata1(bht_rdata1)
  );

endmodule

`default_nettype wire

// ==== logic/btac_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_update
  import btac_pkg::*;
(
  input  logic [addr_width-1:0]      upd_pc0,
  input  logic [addr_width-1:0]      upd_pc1,
  input  logic [addr_width-1:0]      upd_addr0,
  input  logic [addr_width-1:0]      upd_addr1,
  input  logic [1:0]                 upd_tsat0,
  input  logic [1:0]                 upd_tsat1,
  input  logic                       upd_jump0,
  input  logic                       upd_jump1,
  input  resolve_kind_t              kind0,
  input  resolve_kind_t              kind1,
  output logic                       btb_wen,
  output logic [btb_index_width-1:0] btb_waddr,
  output logic [btb_entry_width-1:0] btb_wdata,
  output logic                       bht_wen,
  output logic [bht_index_width-1:0] bht_waddr,
  output logic [1:0]                 bht_wdata
);

  counter_state_t sat0;
  counter_state_t sat1;
  logic           use0;
  logic           write;

  function automatic counter_state_t saturate(input counter_state_t sat, input logic jump);
    if (jump && sat != strong_taken) begin
      return counter_state_t'(sat + 2'd1);
    end else if (!jump && sat != strong_not_taken) begin
      return counter_state_t'(sat - 2'd1);
    end
    return sat;
  endfunction

  assign sat0 = saturate(counter_state_t'(upd_tsat0), upd_jump0);
  assign sat1 = saturate(counter_state_t'(upd_tsat1), upd_jump1);

  assign use0  = kind0 != no_branch; // Lane 1 is dropped when both resolve.
  assign write = use0 || (kind1 != no_branch);

  assign btb_wen   = write;
  assign btb_waddr = use0 ? upd_pc0[btb_index_width:1] : upd_pc1[btb_index_width:1];
  assign btb_wdata = use0 ? {upd_pc0[addr_width-1:btb_index_width+1], upd_addr0}
                          : {upd_pc1[addr_width-1:btb_index_width+1], upd_addr1};

  assign bht_wen   = write;
  assign bht_waddr = use0 ? upd_pc0[bht_index_width:1] : upd_pc1[bht_index_width:1];
  assign bht_wdata = use0 ? sat0 : sat1;

endmodule

`default_nettype wire

// ==== logic/btac_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_resolve
  import btac_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  upd_jump0,
  input  logic                  upd_jump1,
  input  logic                  upd_taken0,
  input  logic                  upd_taken1,
  input  logic [addr_width-1:0] upd_addr0,
  input  logic [addr_width-1:0] upd_addr1,
  input  logic [addr_width-1:0] upd_taddr0,
  input  logic [addr_width-1:0] upd_taddr1,
  input  logic [addr_width-1:0] upd_npc0,
  input  logic [addr_width-1:0] upd_npc1,
  output resolve_kind_t         kind0,
  output resolve_kind_t         kind1,
  output logic                  pred_miss,
  output logic [addr_width-1:0] pred_maddr,
  output logic                  pred_hazard
);

  logic [addr_width-1:0] redirect0;
  logic [addr_width-1:0] redirect1;
  logic                  miss0;
  logic                  miss1;
  logic                  miss_q;
  logic [addr_width-1:0] maddr_q;

  function automatic resolve_kind_t classify(input logic            flush,
                                             input logic            taken,
                                             input logic            jump,
                                             input logic [addr_width-1:0] addr,
                                             input logic [addr_width-1:0] taddr);
    if (flush || (!taken && !jump)) begin
      return no_branch;
    end else if (!taken) begin
      return wrong_not_taken;
    end else if (!jump) begin
      return wrong_taken;
    end else if (addr != taddr) begin
      return wrong_target;
    end
    return correct_taken;
  endfunction

  function automatic logic [addr_width-1:0] redirect(input resolve_kind_t kind,
                                                      input logic [addr_width-1:0] addr,
                                                      input logic [addr_width-1:0] npc);
    case (kind)
      correct_taken, wrong_target, wrong_not_taken: return addr;
      wrong_taken: return npc; // Fall through after a false taken.
      default: return '0;
    endcase
  endfunction

  assign kind0 = classify(clear, upd_taken0, upd_jump0, upd_addr0, upd_taddr0);
  assign kind1 = classify(clear, upd_taken1, upd_jump1, upd_addr1, upd_taddr1);

  assign redirect0 = redirect(kind0, upd_addr0, upd_npc0);
  assign redirect1 = redirect(kind1, upd_addr1, upd_npc1);

  assign miss0 = (kind0 != no_branch) && (kind0 != correct_taken);
  assign miss1 = (kind1 != no_branch) && (kind1 != correct_taken);

  always_ff @(posedge clock) begin
    if (!reset) begin
      miss_q  <= 1'b0;
      maddr_q <= '0;
    end else begin
      miss_q  <= miss0 || miss1;
      maddr_q <= miss0 ? redirect0 : redirect1; // Lane 0 wins.
    end
  end

  assign pred_miss   = miss_q;
  assign pred_maddr  = maddr_q;
  assign pred_hazard = miss0; // Same cycle as the resolve.

endmodule

`default_nettype wire

// ==== logic/btac_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_lookup
  import btac_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clear,
  input  logic                       stall,
  input  logic [addr_width-1:0]      get_pc0,
  input  logic [addr_width-1:0]      get_pc1,
  input  logic [btb_entry_width-1:0] btb_rdata0,
  input  logic [btb_entry_width-1:0] btb_rdata1,
  input  logic [1:0]                 bht_rdata0,
  input  logic [1:0]                 bht_rdata1,
  output logic [btb_index_width-1:0] btb_raddr0,
  output logic [btb_index_width-1:0] btb_raddr1,
  output logic [bht_index_width-1:0] bht_raddr0,
  output logic [bht_index_width-1:0] bht_raddr1,
  output logic                       pred_taken0,
  output logic                       pred_taken1,
  output logic [addr_width-1:0]      pred_taddr0,
  output logic [addr_width-1:0]      pred_taddr1,
  output logic [1:0]                 pred_tsat0,
  output logic [1:0]                 pred_tsat1
);

  logic [addr_width-1:0] pc0_q;
  logic [addr_width-1:0] pc1_q;
  logic [addr_width-1:0] pc0_sel;
  logic [addr_width-1:0] pc1_sel;
  logic                  tag_hit0;
  logic                  tag_hit1;
  logic                  pred_ok;

  // During clear the previous lookup is repeated.
  assign pc0_sel = clear ? pc0_q : get_pc0;
  assign pc1_sel = clear ? pc1_q : get_pc1;

  assign btb_raddr0 = pc0_sel[btb_index_width:1];
  assign btb_raddr1 = pc1_sel[btb_index_width:1];
  assign bht_raddr0 = pc0_sel[bht_index_width:1];
  assign bht_raddr1 = pc1_sel[bht_index_width:1];

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else begin
      pc0_q <= pc0_sel;
      pc1_q <= pc1_sel;
    end
  end

  assign tag_hit0 = btb_rdata0[btb_entry_width-1:addr_width] ==
                    pc0_q[addr_width-1:btb_index_width+1];
  assign tag_hit1 = btb_rdata1[btb_entry_width-1:addr_width] ==
                    pc1_q[addr_width-1:btb_index_width+1];
  assign pred_ok = !stall && !clear;

  assign pred_taken0 = pred_ok && bht_rdata0[1] && tag_hit0;
  assign pred_taken1 = pred_ok && bht_rdata1[1] && tag_hit1;
  assign pred_taddr0 = pred_ok ? btb_rdata0[addr_width-1:0] : '0;
  assign pred_taddr1 = pred_ok ? btb_rdata1[addr_width-1:0] : '0;
  assign pred_tsat0  = pred_ok ? bht_rdata0 : 2'b00; // Counter shown even on tag miss.
  assign pred_tsat1  = pred_ok ? bht_rdata1 : 2'b00;

endmodule

`default_nettype wire

// ==== logic/bht.sv ====
`timescale 1ns/1ps
`default_nettype none

module bht
  import btac_pkg::*;
(
  input  logic                       clock,
  input  logic                       wen,
  input  logic [bht_index_width-1:0] waddr,
  input  logic [1:0]                 wdata,
  input  logic [bht_index_width-1:0] raddr0,
  input  logic [bht_index_width-1:0] raddr1,
  output logic [1:0]                 rdata0,
  output logic [1:0]                 rdata1
);

  logic [1:0] counters [0:bht_entries-1] = '{default: '0}; // All strong not taken.

  always_ff @(posedge clock) begin
    if (wen) begin
      counters[waddr] <= wdata;
    end
    rdata0 <= counters[raddr0];
    rdata1 <= counters[raddr1];
  end

endmodule

`default_nettype wire

// ==== logic/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb
  import btac_pkg::*;
(
  input  logic                       clock,
  input  logic                       wen,
  input  logic [btb_index_width-1:0] waddr,
  input  logic [btb_entry_width-1:0] wdata,
  input  logic [btb_index_width-1:0] raddr0,
  input  logic [btb_index_width-1:0] raddr1,
  output logic [btb_entry_width-1:0] rdata0,
  output logic [btb_entry_width-1:0] rdata1
);

  // Tag and target per entry, empty at start.
  logic [btb_entry_width-1:0] entries [0:btb_entries-1] = '{default: '0};

  always_ff @(posedge clock) begin
    if (wen) begin
      entries[waddr] <= wdata;
    end
    rdata0 <= entries[raddr0]; // Old data on a same-cycle write.
    rdata1 <= entries[raddr1];
  end

endmodule

`default_nettype wire

// ==== logic/btac_pkg.sv ====
`default_nettype none

package btac_pkg;

  localparam int addr_width = 32;

  // Direct-mapped BTB, indexed by address bits 6:1.
  localparam int btb_entries = 64;
  localparam int btb_index_width = $clog2(btb_entries);
  localparam int btb_tag_width = addr_width - btb_index_width - 1;
  localparam int btb_entry_width = btb_tag_width + addr_width; // Tag above target.

  // BHT, indexed by address bits 8:1.
  localparam int bht_entries = 256;
  localparam int bht_index_width = $clog2(bht_entries);

  // Upper bit set means predict taken.
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
  } counter_state_t;

  typedef enum logic [2:0] {
    no_branch       = 3'd0,
    correct_taken   = 3'd1,
    wrong_target    = 3'd2,
    wrong_taken     = 3'd3,
    wrong_not_taken = 3'd4
  } resolve_kind_t;

endpackage

`default_nettype wire
